// ==== verif/vWritePatterns.txt ====
// word 0 test count; per test: extAddr len pingPong reverseB | A iter period duty shift incr |
// B iter period duty start shift incr delay iter2 shift2 | startB | check nIn nExp | in0 | expected
6
// ping-pong write of half 0, A reads the unwritten half
80001000 07 1 0  1 8 8 0 1  1 8 8 0 0 1 0 1 0  0  0 8 0
a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
// ping-pong swap, read-back of half 0
80002000 07 1 0  1 8 8 0 1  1 8 8 0 0 1 0 1 0  0  1 8 8
b0000000 b0000001 b0000002 b0000003 b0000004 b0000005 b0000006 b0000007
a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
// bit-reversed write
80003000 00 0 1  1 1 1 0 0  1 8 8 0 0 1 0 1 0  0  0 8 0
c0000000 c0000001 c0000002 c0000003 c0000004 c0000005 c0000006 c0000007
// reversed read-back with stride 128
80004000 07 0 0  1 8 8 0 80  1 1 0 0 0 0 0 1 0  0  1 0 8
c0000000 c0000004 c0000002 c0000006 c0000001 c0000005 c0000003 c0000007
// two-level duty write of B, A reads half 1
80005000 07 1 0  1 8 8 0 1  2 4 2 0 3 1 3 2 5  0  1 8 8
d0000000 d0000001 d0000002 d0000003 d0000004 d0000005 d0000006 d0000007
c0000001 b0000001 b0000002 b0000003 b0000004 b0000005 b0000006 b0000007
// read-back of 0..7 with gaps
80006000 07 0 0  1 8 8 0 1  1 1 0 0 0 0 0 1 0  0  1 0 8
d0000000 d0000001 a0000002 a0000003 a0000004 d0000002 d0000003 a0000007

// ==== sources.f ====
design/vwBusPkg.sv
design/vwCfgPkg.sv
design/addrGenStream.sv
design/addrGenNested.sv
design/memReader.sv
design/dualPortMem.sv
design/vWrite.sv
design/vWriteTop.sv
verif/vWriteTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module vWriteTb -o vWriteSim
./obj_dir/vWriteSim > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
   exit 1
fi
if ! grep -q "No errors" sim.log; then
   exit 1
fi

// ==== verif/vWriteTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module vWriteTb
   import vwCfgPkg::*, vwBusPkg::*;
();

   // words per test record before the in0 and expected words
   localparam int recWords = 22;

   logic       clk;
   logic       rst;
   logic       run;
   vwCfg_t     cfg;
   busData_t   in0;
   busReq_t    busReq;
   logic       busReady;
   logic       busLast;
   logic       done;

   logic [31:0] pat [0:511];
   logic [31:0] lfsr;
   int          errCnt;
   int          checkCnt;
   int          cycleCnt;
   int          timeoutLimit = 100000;

   vWriteTop u_vWriteTop (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfg),
      .in0      (in0),
      .busReq   (busReq),
      .busReady (busReady),
      .busLast  (busLast),
      .done     (done)
   );

   initial
      clk = 1'b0;

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycleCnt = cycleCnt + 1;
      if (cycleCnt >= timeoutLimit)
      begin
         $display("timeout: the tests did not finish within %0d cycles", timeoutLimit);
         $display("checks: %0d, errors: %0d", checkCnt, errCnt + 1);
         $display("Errors found");
         $finish;
      end
   end

   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h80200003;
      else
         return s >> 1;
   endfunction

   task automatic takeBit(output logic b);
      b = lfsr[0];
      lfsr = lfsrNext(lfsr);
   endtask

   task automatic checkVal(input string name, input logic [31:0] act, input logic [31:0] exp);
      checkCnt++;
      if (act !== exp)
      begin
         $display("Error: %s is %h, expected %h", name, act, exp);
         errCnt++;
      end
   endtask

   // B writes on the first duty cycles of each period once its delay is over
   function automatic logic bEnabled(input int cyc, input nestCfg_t g);
      int t;
      int total;
      t = cyc - int'(g.delay);
      total = int'(g.period) * int'(g.iterations) * int'(g.iterations2);
      if (t < 0 || t >= total)
         return 1'b0;
      return (t % int'(g.period)) < int'(g.duty);
   endfunction

   task automatic doRun(input int base);
      vwCfg_t  c;
      logic    chk;
      logic    rdy;
      logic    lastSeen;
      logic    finished;
      int      nIn;
      int      nExp;
      int      inPtr;
      int      expPtr;
      int      inIdx;
      int      beatCnt;
      int      cyc;
      int      lastCyc;
      int      bEndCyc;
      c.extAddr          = pat[base];
      c.length           = busLen_t'(pat[base+1]);
      c.pingPong         = pat[base+2][0];
      c.reverseB         = pat[base+3][0];
      c.genA.iterations  = memAddr_t'(pat[base+4]);
      c.genA.period      = period_t'(pat[base+5]);
      c.genA.duty        = period_t'(pat[base+6]);
      c.genA.shift       = memAddr_t'(pat[base+7]);
      c.genA.incr        = memAddr_t'(pat[base+8]);
      c.genB.iterations  = memAddr_t'(pat[base+9]);
      c.genB.period      = period_t'(pat[base+10]);
      c.genB.duty        = period_t'(pat[base+11]);
      c.genB.start       = memAddr_t'(pat[base+12]);
      c.genB.shift       = memAddr_t'(pat[base+13]);
      c.genB.incr        = memAddr_t'(pat[base+14]);
      c.genB.delay       = period_t'(pat[base+15]);
      c.genB.iterations2 = memAddr_t'(pat[base+16]);
      c.genB.shift2      = memAddr_t'(pat[base+17]);
      c.startB           = memAddr_t'(pat[base+18]);
      chk    = pat[base+19][0];
      nIn    = int'(pat[base+20]);
      nExp   = int'(pat[base+21]);
      inPtr  = base + recWords;
      expPtr = inPtr + nIn;
      // first cycle in which B reports done
      bEndCyc = int'(c.genB.delay)
              + int'(c.genB.period) * int'(c.genB.iterations) * int'(c.genB.iterations2);

      @(negedge clk);
      checkVal("done", 32'(done), 32'h1);
      @(posedge clk);
      #1;
      cfg = c;
      run = 1'b1;
      busReady = 1'b0;
      busLast = 1'b0;
      @(posedge clk);
      #1;
      run = 1'b0;
      cyc = 0;
      inIdx = 0;
      beatCnt = 0;
      lastSeen = 1'b0;
      lastCyc = 0;
      finished = 1'b0;
      while (!finished)
      begin
         if (bEnabled(cyc, c.genB) && inIdx < nIn)
         begin
            in0 = pat[inPtr+inIdx];
            inIdx++;
         end
         else
         begin
            in0 = '0;
         end
         takeBit(rdy);
         busReady = rdy;
         busLast = (beatCnt == int'(c.length));
         @(negedge clk);
         if (cyc == 0)
            checkVal("done", 32'(done), 32'h0);
         if (done)
         begin
            if (!lastSeen)
            begin
               $display("done went high before the last bus beat was accepted");
               errCnt++;
            end
            else if (lastCyc >= bEndCyc)
               checkVal("done rise cycle", cyc, lastCyc + 1);
            else
               checkVal("done rise cycle", cyc, bEndCyc + 1);
            finished = 1'b1;
         end
         if (busReq.valid && busReady)
         begin
            checkVal("busReq.addr", busReq.addr, c.extAddr);
            checkVal("busReq.len", 32'(busReq.len), 32'(c.length));
            checkVal("busReq.wstrb", 32'(busReq.wstrb), 32'hf);
            if (chk && beatCnt < nExp)
               checkVal("busReq.wdata", busReq.wdata, pat[expPtr+beatCnt]);
            if (busLast)
            begin
               lastSeen = 1'b1;
               lastCyc = cyc;
            end
            beatCnt++;
         end
         @(posedge clk);
         #1;
         cyc++;
      end
      checkVal("beat count", beatCnt, int'(c.length) + 1);
      in0 = '0;
      busReady = 1'b0;
      busLast = 1'b0;
   endtask

   initial
   begin
      int nTests;
      int p;
      rst = 1'b1;
      run = 1'b0;
      cfg = '0;
      in0 = '0;
      busReady = 1'b0;
      busLast = 1'b0;
      lfsr = 32'headd1810;
      errCnt = 0;
      checkCnt = 0;
      cycleCnt = 0;
      nTests = 0;
      $readmemh("verif/vWritePatterns.txt", pat);
      if ($isunknown(pat[0]) || pat[0] == 32'h0)
      begin
         $display("pattern file is missing or holds no tests");
         errCnt++;
      end
      else
      begin
         nTests = int'(pat[0]);
      end

      // timeout from the total length of the pattern data
      p = 1;
      for (int t = 0; t < nTests; t++)
         p = p + recWords + int'(pat[p+20]) + int'(pat[p+21]);
      timeoutLimit = 20 * p + 200;

      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      checkVal("done", 32'(done), 32'h1);

      p = 1;
      for (int t = 0; t < nTests; t++)
      begin
         doRun(p);
         p = p + recWords + int'(pat[p+20]) + int'(pat[p+21]);
      end

      $display("checks: %0d, errors: %0d", checkCnt, errCnt);
      if (errCnt == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/vWriteTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module vWriteTop
   import vwCfgPkg::*, vwBusPkg::*;
#(
   parameter int dataW    = defDataW,
   parameter int memAddrW = defMemAddrW
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  vwCfg_t    cfg,
   input  busData_t  in0,
   output busReq_t   busReq,
   input  logic      busReady,
   input  logic      busLast,
   output logic      done
);

   logic       wrEn;
   memAddr_t   wrAddr;
   busData_t   wrData;
   logic       rdEn;
   memAddr_t   rdAddr;
   busData_t   rdData;

   vWrite #(.dataW(dataW), .memAddrW(memAddrW)) uVWrite (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfg),
      .in0      (in0),
      .bus      (busReq),
      .busReady (busReady),
      .busLast  (busLast),
      .wrEn     (wrEn),
      .wrAddr   (wrAddr),
      .wrData   (wrData),
      .rdEn     (rdEn),
      .rdAddr   (rdAddr),
      .rdData   (rdData),
      .done     (done)
   );

   dualPortMem #(.dataW(dataW), .memAddrW(memAddrW)) uMem (
      .clk    (clk),
      .wrEn   (wrEn),
      .wrAddr (wrAddr),
      .wrData (wrData),
      .rdEn   (rdEn),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

endmodule

`default_nettype wire

// ==== design/vWrite.sv ====
`timescale 1ns/100ps
`default_nettype none

module vWrite
   import vwCfgPkg::*, vwBusPkg::*;
#(
   parameter int dataW    = defDataW,
   parameter int memAddrW = defMemAddrW
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  vwCfg_t    cfg,
   input  busData_t  in0,
   output busReq_t   bus,
   input  logic      busReady,
   input  logic      busLast,
   output logic      wrEn,
   output memAddr_t  wrAddr,
   output busData_t  wrData,
   output logic      rdEn,
   output memAddr_t  rdAddr,
   input  busData_t  rdData,
   output logic      done
);

   logic       ppState;
   memAddr_t   startA;
   memAddr_t   startB;
   logic       genValid;
   logic       genReady;
   memAddr_t   genAddr;
   logic       genBDone;
   logic       memEnB;
   memAddr_t   rawAddrB;
   logic       busValid;
   busData_t   busData;
   logic       doneA;
   logic       doneB;

   function automatic memAddr_t reverseBits(memAddr_t word);
      memAddr_t res;
      for (int i = 0; i < memAddrW; i++)
         res[i] = word[memAddrW-1-i];
      return res;
   endfunction

   // A reads the half that B is not writing
   always_comb
   begin
      startA = '0;
      startA[memAddrW-1] = cfg.pingPong & ~ppState;
   end

   always_comb
   begin
      startB = cfg.startB;
      if (cfg.pingPong)
         startB[memAddrW-1] = ppState;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ppState <= 1'b0;
         doneA   <= 1'b1;
         doneB   <= 1'b1;
      end
      else if (run)
      begin
         ppState <= cfg.pingPong & ~ppState;
         doneA   <= 1'b0;
         doneB   <= 1'b0;
      end
      else
      begin
         doneB <= genBDone;
         if (busValid & busReady & busLast)
            doneA <= 1'b1;
      end
   end

   assign done = doneA & doneB;

   addrGenStream #(.memAddrW(memAddrW)) uGenA (
      .clk   (clk),
      .rst   (rst),
      .run   (run),
      .cfg   (cfg.genA),
      .start (startA),
      .ready (genReady),
      .valid (genValid),
      .addr  (genAddr),
      .done  ()
   );

   addrGenNested #(.memAddrW(memAddrW)) uGenB (
      .clk   (clk),
      .rst   (rst),
      .run   (run),
      .cfg   (cfg.genB),
      .start (startB),
      .memEn (memEnB),
      .addr  (rawAddrB),
      .done  (genBDone)
   );

   memReader #(.dataW(dataW)) uReader (
      .clk    (clk),
      .rst    (rst),
      .sValid (genValid),
      .sReady (genReady),
      .sAddr  (genAddr),
      .mValid (busValid),
      .mReady (busReady),
      .mData  (busData),
      .rdEn   (rdEn),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

   // every enabled B cycle stores in0
   assign wrEn   = memEnB;
   assign wrAddr = cfg.reverseB ? reverseBits(rawAddrB) : rawAddrB;
   assign wrData = in0;

   always_comb
   begin
      bus.valid = busValid;
      bus.addr  = cfg.extAddr;
      bus.wdata = busData;
      bus.wstrb = '1;
      bus.len   = cfg.length;
   end

endmodule

`default_nettype wire

// ==== design/dualPortMem.sv ====
`timescale 1ns/100ps
`default_nettype none

module dualPortMem
   import vwCfgPkg::*, vwBusPkg::*;
#(
   parameter int dataW    = defDataW,
   parameter int memAddrW = defMemAddrW
)
(
   input  logic      clk,
   input  logic      wrEn,
   input  memAddr_t  wrAddr,
   input  busData_t  wrData,
   input  logic      rdEn,
   input  memAddr_t  rdAddr,
   output busData_t  rdData
);

   logic [dataW-1:0] mem [2**memAddrW];

   // read before write on the same address
   always_ff @(posedge clk)
   begin
      if (wrEn)
         mem[wrAddr] <= wrData;
      if (rdEn)
         rdData <= mem[rdAddr];
   end

endmodule

`default_nettype wire

// ==== design/memReader.sv ====
`timescale 1ns/100ps
`default_nettype none

module memReader
   import vwCfgPkg::*, vwBusPkg::*;
#(
   parameter int dataW = defDataW
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      sValid,
   output logic      sReady,
   input  memAddr_t  sAddr,
   output logic      mValid,
   input  logic      mReady,
   output busData_t  mData,
   output logic      rdEn,
   output memAddr_t  rdAddr,
   input  busData_t  rdData
);

   logic [dataW-1:0] fifo [2];
   logic             wrPtr;
   logic             rdPtr;
   logic [1:0]       count;
   logic [2:0]       occ;
   logic             pending;
   logic             push;
   logic             pop;

   // read issued last cycle, its data is on rdData now
   assign push = pending;
   assign pop  = mValid & mReady;

   // fifo words plus the read in flight never exceed two
   assign occ    = {1'b0, count} + {2'b00, pending};
   assign sReady = occ < ({2'b00, pop} + 3'd2);

   assign rdEn   = sValid & sReady;
   assign rdAddr = sAddr;

   assign mValid = count != 2'd0;
   assign mData  = fifo[rdPtr];

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pending <= 1'b0;
         wrPtr   <= 1'b0;
         rdPtr   <= 1'b0;
         count   <= '0;
      end
      else
      begin
         pending <= rdEn;
         if (push)
            wrPtr <= ~wrPtr;
         if (pop)
            rdPtr <= ~rdPtr;
         count <= count + {1'b0, push} - {1'b0, pop};
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         fifo[wrPtr] <= rdData;
   end

endmodule

`default_nettype wire

// ==== design/addrGenNested.sv ====
`timescale 1ns/100ps
`default_nettype none

module addrGenNested
   import vwCfgPkg::*;
#(
   parameter int memAddrW = defMemAddrW
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  nestCfg_t  cfg,
   input  memAddr_t  start,
   output logic      memEn,
   output memAddr_t  addr,
   output logic      done
);

   typedef enum logic [1:0] {stIdle, stDelay, stRun} state_t;

   state_t              state;
   period_t             delayCnt;
   period_t             perCnt;
   logic [memAddrW-1:0] iterCnt;
   logic [memAddrW-1:0] iter2Cnt;
   logic                dutyOn;
   logic                perEnd;
   logic                innerEnd;
   logic                outerEnd;

   assign dutyOn   = perCnt < cfg.duty;
   assign perEnd   = perCnt == cfg.period - 1'b1;
   assign innerEnd = perEnd && (iterCnt == cfg.iterations - 1'b1);
   assign outerEnd = innerEnd && (iter2Cnt == cfg.iterations2 - 1'b1);

   assign memEn = (state == stRun) && dutyOn;
   assign done  = state == stIdle;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= stIdle;
         delayCnt <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         iter2Cnt <= '0;
         addr     <= '0;
      end
      else if (run)
      begin
         state    <= (cfg.delay == '0) ? stRun : stDelay;
         delayCnt <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         iter2Cnt <= '0;
         addr     <= start;
      end
      else
      begin
         case (state)
            stDelay:
            begin
               if (delayCnt == cfg.delay - 1'b1)
                  state <= stRun;
               else
                  delayCnt <= delayCnt + 1'b1;
            end
            stRun:
            begin
               // no stall here, one step per cycle
               addr <= addr
                     + (dutyOn ? cfg.incr : '0)
                     + (perEnd ? cfg.shift : '0)
                     + (innerEnd ? cfg.shift2 : '0);
               if (perEnd)
               begin
                  perCnt <= '0;
                  if (innerEnd)
                  begin
                     iterCnt <= '0;
                     if (outerEnd)
                        state <= stIdle;
                     else
                        iter2Cnt <= iter2Cnt + 1'b1;
                  end
                  else
                  begin
                     iterCnt <= iterCnt + 1'b1;
                  end
               end
               else
               begin
                  perCnt <= perCnt + 1'b1;
               end
            end
            default:
            begin
               state <= stIdle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/addrGenStream.sv ====
`timescale 1ns/100ps
`default_nettype none

module addrGenStream
   import vwCfgPkg::*;
#(
   parameter int memAddrW = defMemAddrW
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  genCfg_t   cfg,
   input  memAddr_t  start,
   input  logic      ready,
   output logic      valid,
   output memAddr_t  addr,
   output logic      done
);

   logic                active;
   logic [memAddrW-1:0] iterCnt;
   period_t             perCnt;
   logic                dutyOn;
   logic                perEnd;
   logic                lastIter;
   logic                step;

   assign dutyOn   = perCnt < cfg.duty;
   assign perEnd   = perCnt == cfg.period - 1'b1;
   assign lastIter = iterCnt == cfg.iterations - 1'b1;

   assign valid = active & dutyOn;
   // idle duty cycles advance without waiting for ready
   assign step  = active & (~dutyOn | ready);
   assign done  = ~active;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         active  <= 1'b0;
         iterCnt <= '0;
         perCnt  <= '0;
         addr    <= '0;
      end
      else if (run)
      begin
         active  <= 1'b1;
         iterCnt <= '0;
         perCnt  <= '0;
         addr    <= start;
      end
      else if (step)
      begin
         // incr on enabled cycles, shift on the last cycle of a period
         addr <= addr + (dutyOn ? cfg.incr : '0) + (perEnd ? cfg.shift : '0);
         if (perEnd)
         begin
            perCnt <= '0;
            if (lastIter)
               active <= 1'b0;
            else
               iterCnt <= iterCnt + 1'b1;
         end
         else
         begin
            perCnt <= perCnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/vwCfgPkg.sv ====
`default_nettype none

package vwCfgPkg;

   import vwBusPkg::*;

   localparam int defMemAddrW = 10;
   localparam int defPeriodW  = 10;

   typedef logic [defMemAddrW-1:0] memAddr_t;
   typedef logic [defPeriodW-1:0]  period_t;

   typedef struct packed {
      memAddr_t   iterations;
      period_t    period;
      period_t    duty;
      memAddr_t   shift;
      memAddr_t   incr;
   } genCfg_t;

   typedef struct packed {
      memAddr_t   iterations;
      period_t    period;
      period_t    duty;
      memAddr_t   start;
      memAddr_t   shift;
      memAddr_t   incr;
      period_t    delay;
      memAddr_t   iterations2;
      memAddr_t   shift2;
   } nestCfg_t;

   typedef struct packed {
      busAddr_t   extAddr;
      busLen_t    length;
      logic       pingPong;
      logic       reverseB;
      genCfg_t    genA;
      nestCfg_t   genB;
      // B start before the ping-pong half is applied
      memAddr_t   startB;
   } vwCfg_t;

endpackage

`default_nettype wire

// ==== design/vwBusPkg.sv ====
`default_nettype none

package vwBusPkg;

   localparam int defDataW = 32;

   typedef logic [31:0]          busAddr_t;
   // beat count minus one
   typedef logic [7:0]           busLen_t;
   typedef logic [defDataW-1:0]  busData_t;

   typedef struct packed {
      logic                      valid;
      busAddr_t                  addr;
      busData_t                  wdata;
      logic [defDataW/8-1:0]     wstrb;
      busLen_t                   len;
   } busReq_t;

endpackage

`default_nettype wire
